// File: merge_cases.txt
# Columns: case name, words from source 0, words from source 1, stall mode.
# Stall mode 0 keeps out_ready high, 1 starts equal bursts against a stalled output,
# 2 fills source 0 until in_ready_0 drops, 3 drives out_ready from the LFSR.
one_word_src0        1    0   0
one_word_src1        0    1   0
short_both           4    4   0
uneven_both          9    3   0
long_src0           40    0   0
long_src1            0   40   0
long_both           32   32   0
priority_one         1    1   1
priority_four        4    4   1
priority_eight       8    8   1
priority_twelve     12   12   1
backpressure_a      40    0   2
backpressure_b      48    0   2
random_short         6    6   3
random_src0_only    30    0   3
random_src1_only     0   30   3
random_uneven       25   10   3
random_long         64   64   3
after_random_free   16   16   0
priority_again      10   10   1
backpressure_again  40    0   2
random_final        50   45   3

// File: verilog.f
+incdir+.
stream_pkg.sv
fifo_pkg.sv
input_fifo.sv
priority_arbiter.sv
cdc_fifo.sv
stream_merge_top.sv
tb_stream_merge.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_stream_merge -f verilog.f -o sim_stream_merge

output=$(./obj_dir/sim_stream_merge)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: tb_stream_merge.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module tb_stream_merge;
    import stream_pkg::*;

    localparam int MODE_FREE = 0;
    localparam int MODE_PRIORITY = 1;
    localparam int MODE_BACKPRESSURE = 2;
    localparam int MODE_RANDOM = 3;
    localparam int STALL_NONE = 0;
    localparam int STALL_HOLD = 1;
    localparam int STALL_RANDOM = 2;
    localparam int WAIT_READY = 0;
    localparam int WAIT_STALLED = 1;
    localparam int WAIT_DRAINED = 2;
    localparam int WAIT_AF_LOW = 3;
    localparam int CYCLE_LIMIT = 4000;
    // Beats that fit past an input FIFO in the crossing FIFO, its output register and the arbiter.
    localparam int DOWNSTREAM_WORDS = `MERGE_CDC_DEPTH + 2;

    logic        clk = 1'b0;
    logic        clk_out = 1'b0;
    logic        arst_n;
    data_word_t  in_data_0;
    data_word_t  in_data_1;
    logic        in_valid_0;
    logic        in_valid_1;
    logic        in_ready_0;
    logic        in_ready_1;
    logic        in_almost_full_0;
    logic        in_almost_full_1;
    merge_beat_t out_beat;
    logic        out_valid;
    logic        out_ready = 1'b0;

    logic [31:0] data_lfsr = 32'ha325;
    logic [31:0] stall_lfsr = 32'ha325;
    int          stall_mode = STALL_NONE;
    data_word_t  exp_q0 [$];
    data_word_t  exp_q1 [$];
    merge_beat_t rx_q [$];
    string       case_name = "reset";
    int          errors = 0;
    int          received = 0;
    int          accepted = 0;
    int          cases_run = 0;
    int          cases_failed = 0;
    logic        prio_order = 1'b0;
    logic        seen_src0 = 1'b0;
    logic        full_seen = 1'b0;
    logic        timed_out = 1'b0;

    always #2 clk = ~clk;
    always #3 clk_out = ~clk_out;

    stream_merge_top uut (
        .clk              (clk),
        .clk_out          (clk_out),
        .arst_n           (arst_n),
        .in_data_0        (in_data_0),
        .in_data_1        (in_data_1),
        .in_valid_0       (in_valid_0),
        .in_valid_1       (in_valid_1),
        .in_ready_0       (in_ready_0),
        .in_ready_1       (in_ready_1),
        .in_almost_full_0 (in_almost_full_0),
        .in_almost_full_1 (in_almost_full_1),
        .out_beat         (out_beat),
        .out_valid        (out_valid),
        .out_ready        (out_ready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic data_word_t next_byte();
        data_word_t b;
        b = '0;
        for (int i = 0; i < `MERGE_DATA_W; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            b = {b[`MERGE_DATA_W-2:0], data_lfsr[0]};
        end
        return b;
    endfunction

    // The consumer lives in the clk_out domain.
    always @(posedge clk_out) begin
        if (stall_mode == STALL_RANDOM) begin
            out_ready  <= stall_lfsr[0];
            stall_lfsr <= lfsr_step(stall_lfsr);
        end else begin
            out_ready <= (stall_mode == STALL_NONE);
        end
    end

    always @(posedge clk_out) begin
        if (arst_n && out_valid && out_ready) begin
            rx_q.push_back(out_beat);
        end
    end

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("error %s %s: expected %0d, actual %0d", case_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("%s: %s", case_name, text);
        errors++;
    endtask

    task automatic check_beat(input merge_beat_t b);
        received++;
        if (b.source == 1'b1) begin
            if (prio_order) begin
                compare_value("source 0 beats seen before source 1", 0, int'(seen_src0));
            end
            if (exp_q1.size() == 0) begin
                report_problem("a beat from source 1 arrived that was never sent");
            end else begin
                compare_value("source 1 data", int'(exp_q1.pop_front()), int'(b.data));
            end
        end else begin
            seen_src0 = 1'b1;
            if (exp_q0.size() == 0) begin
                report_problem("a beat from source 0 arrived that was never sent");
            end else begin
                compare_value("source 0 data", int'(exp_q0.pop_front()), int'(b.data));
            end
        end
    endtask

    task automatic take_beats();
        while (rx_q.size() > 0) begin
            check_beat(rx_q.pop_front());
        end
    endtask

    task automatic wait_for(input int what, input string text);
        int   cycles;
        logic hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && !timed_out) begin
            @(posedge clk);
            take_beats();
            case (what)
                WAIT_READY:   hit = in_ready_0 && in_ready_1;
                WAIT_STALLED: hit = !out_ready;
                WAIT_DRAINED: hit = (exp_q0.size() == 0) && (exp_q1.size() == 0);
                default:      hit = !in_almost_full_0;
            endcase
            cycles++;
            if (!hit && cycles > CYCLE_LIMIT) begin
                timed_out = 1'b1;
                report_problem({"timed out waiting for ", text});
            end
        end
    endtask

    // A word counts as sent on the edge where valid and ready were both high.
    task automatic send_words(input int n0, input int n1, input logic stop_on_full);
        int sent0;
        int sent1;
        int cycles;
        sent0 = 0;
        sent1 = 0;
        cycles = 0;
        forever begin
            @(posedge clk);
            take_beats();
            if (in_valid_0 && in_ready_0) begin
                exp_q0.push_back(in_data_0);
                sent0++;
                accepted++;
            end
            if (in_valid_1 && in_ready_1) begin
                exp_q1.push_back(in_data_1);
                sent1++;
                accepted++;
            end
            if (stop_on_full && in_valid_0 && !in_ready_0) begin
                full_seen = 1'b1;
                in_valid_0 <= 1'b0;
                break;
            end
            if (sent0 < n0 && (!in_valid_0 || in_ready_0)) begin
                in_data_0  <= next_byte();
                in_valid_0 <= 1'b1;
            end else if (sent0 >= n0) begin
                in_valid_0 <= 1'b0;
            end
            if (sent1 < n1 && (!in_valid_1 || in_ready_1)) begin
                in_data_1  <= next_byte();
                in_valid_1 <= 1'b1;
            end else if (sent1 >= n1) begin
                in_valid_1 <= 1'b0;
            end
            if (sent0 >= n0 && sent1 >= n1) begin
                break;
            end
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                in_valid_0 <= 1'b0;
                in_valid_1 <= 1'b0;
                timed_out = 1'b1;
                report_problem("timed out before all source words were accepted");
                break;
            end
        end
    endtask

    task automatic run_case(input int n0, input int n1, input int mode);
        int errors_before;
        errors_before = errors;
        received = 0;
        accepted = 0;
        seen_src0 = 1'b0;
        full_seen = 1'b0;
        prio_order = (mode == MODE_PRIORITY);
        if (mode == MODE_FREE) begin
            stall_mode = STALL_NONE;
        end else if (mode == MODE_RANDOM) begin
            stall_mode = STALL_RANDOM;
        end else begin
            stall_mode = STALL_HOLD;
            wait_for(WAIT_STALLED, "out_ready to go low");
        end
        send_words(n0, n1, mode == MODE_BACKPRESSURE);
        if (mode == MODE_BACKPRESSURE && !timed_out) begin
            if (!full_seen) begin
                report_problem("in_ready_0 never dropped while the output was stalled");
            end
            compare_value("almost_full when in_ready dropped", 1, int'(in_almost_full_0));
            compare_value("almost_full_1 with source 1 idle", 0, int'(in_almost_full_1));
            stall_mode = STALL_NONE;
            wait_for(WAIT_AF_LOW, "in_almost_full_0 to fall");
            compare_value("input words left when almost_full fell", 1,
                          int'(exp_q0.size() > DOWNSTREAM_WORDS));
        end
        if (mode == MODE_PRIORITY) begin
            stall_mode = STALL_NONE;
        end
        wait_for(WAIT_DRAINED, "the output to drain");
        // Give a stray extra beat time to show up.
        repeat (20) @(posedge clk);
        take_beats();
        compare_value("source 0 words left", 0, exp_q0.size());
        compare_value("source 1 words left", 0, exp_q1.size());
        compare_value("beats received", accepted, received);
        compare_value("almost_full_0 after drain", 0, int'(in_almost_full_0));
        compare_value("almost_full_1 after drain", 0, int'(in_almost_full_1));
        exp_q0.delete();
        exp_q1.delete();
        cases_run++;
        if (errors != errors_before) begin
            cases_failed++;
        end
        $display("case %s: %0d of %0d beats, %s", case_name, received, accepted,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        int    code;
        int    n0;
        int    n1;
        int    mode;
        string line;
        arst_n = 1'b0;
        in_data_0 = '0;
        in_data_1 = '0;
        in_valid_0 = 1'b0;
        in_valid_1 = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        wait_for(WAIT_READY, "in_ready after reset");
        compare_value("almost_full_0 after reset", 0, int'(in_almost_full_0));
        compare_value("almost_full_1 after reset", 0, int'(in_almost_full_1));
        fd = $fopen("merge_cases.txt", "r");
        if (fd == 0) begin
            report_problem("could not open merge_cases.txt");
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %d %d %d", case_name, n0, n1, mode) == 4) begin
                run_case(n0, n1, mode);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("cases run %0d, cases failed %0d, errors %0d", cases_run, cases_failed, errors);
        if (errors == 0 && cases_run > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: stream_merge_top.sv
`timescale 1ns/1ps

module stream_merge_top (
    input  logic                    clk,
    input  logic                    clk_out,
    input  logic                    arst_n,
    input  stream_pkg::data_word_t  in_data_0,
    input  stream_pkg::data_word_t  in_data_1,
    input  logic                    in_valid_0,
    input  logic                    in_valid_1,
    output logic                    in_ready_0,
    output logic                    in_ready_1,
    output logic                    in_almost_full_0,
    output logic                    in_almost_full_1,
    output stream_pkg::merge_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import stream_pkg::*;

    data_word_t  fifo_0_data;
    logic        fifo_0_valid;
    logic        fifo_0_ready;
    data_word_t  fifo_1_data;
    logic        fifo_1_valid;
    logic        fifo_1_ready;
    merge_beat_t arb_beat;
    logic        arb_valid;
    logic        arb_ready;

    input_fifo in_fifo_0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_data     (in_data_0),
        .in_valid    (in_valid_0),
        .in_ready    (in_ready_0),
        .almost_full (in_almost_full_0),
        .out_data    (fifo_0_data),
        .out_valid   (fifo_0_valid),
        .out_ready   (fifo_0_ready)
    );

    input_fifo in_fifo_1 (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_data     (in_data_1),
        .in_valid    (in_valid_1),
        .in_ready    (in_ready_1),
        .almost_full (in_almost_full_1),
        .out_data    (fifo_1_data),
        .out_valid   (fifo_1_valid),
        .out_ready   (fifo_1_ready)
    );

    // Source 1 has strict priority over source 0.
    priority_arbiter arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .src0_data  (fifo_0_data),
        .src1_data  (fifo_1_data),
        .src0_valid (fifo_0_valid),
        .src1_valid (fifo_1_valid),
        .src0_ready (fifo_0_ready),
        .src1_ready (fifo_1_ready),
        .beat       (arb_beat),
        .beat_valid (arb_valid),
        .beat_ready (arb_ready)
    );

    cdc_fifo out_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_beat   (arb_beat),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .clk_out   (clk_out),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: cdc_fifo.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module cdc_fifo (
    input  logic                    clk,
    input  logic                    arst_n,
    input  stream_pkg::merge_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    clk_out,
    output stream_pkg::merge_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import stream_pkg::*;
    import fifo_pkg::*;

    localparam int PTR_W  = $bits(cdc_ptr_t);
    localparam int ADDR_W = PTR_W - 1;

    function automatic cdc_ptr_t to_gray(cdc_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    merge_beat_t mem [`MERGE_CDC_DEPTH];

    logic [1:0] wr_rst_q;
    logic [1:0] rd_rst_q;
    logic       wr_rst_n;
    logic       rd_rst_n;

    cdc_ptr_t   wr_bin;
    cdc_ptr_t   wr_bin_next;
    cdc_ptr_t   wr_gray;
    cdc_ptr_t   wr_gray_next;
    cdc_ptr_t   rd_gray_meta;
    cdc_ptr_t   rd_gray_sync;
    logic       wr_en;
    logic       full_next;

    cdc_ptr_t   rd_bin;
    cdc_ptr_t   rd_bin_next;
    cdc_ptr_t   rd_gray;
    cdc_ptr_t   wr_gray_meta;
    cdc_ptr_t   wr_gray_sync;
    logic       rd_en;
    logic       empty;
    logic       load_out;

    // Each side releases reset two edges after arst_n rises in its own clock.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_rst_q <= '0;
        end else begin
            wr_rst_q <= {wr_rst_q[0], 1'b1};
        end
    end

    always_ff @(posedge clk_out or negedge arst_n) begin
        if (!arst_n) begin
            rd_rst_q <= '0;
        end else begin
            rd_rst_q <= {rd_rst_q[0], 1'b1};
        end
    end

    assign wr_rst_n = wr_rst_q[1];
    assign rd_rst_n = rd_rst_q[1];

    assign wr_en        = in_valid && in_ready;
    assign wr_bin_next  = wr_bin + cdc_ptr_t'(wr_en);
    assign wr_gray_next = to_gray(wr_bin_next);

    // Full when the write pointer is one lap ahead, which in Gray form flips
    // the two top bits of the synchronized read pointer.
    assign full_next = (wr_gray_next ==
                        {~rd_gray_sync[PTR_W-1:PTR_W-2], rd_gray_sync[PTR_W-3:0]});

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bin[ADDR_W-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
            in_ready     <= 1'b0;
        end else begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= wr_gray_next;
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
            in_ready     <= !full_next;
        end
    end

    assign empty       = (rd_gray == wr_gray_sync);
    assign load_out    = !out_valid || out_ready;
    assign rd_en       = load_out && !empty;
    assign rd_bin_next = rd_bin + cdc_ptr_t'(rd_en);

    always_ff @(posedge clk_out) begin
        if (rd_en) begin
            out_beat <= mem[rd_bin[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk_out or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
            out_valid    <= 1'b0;
        end else begin
            rd_bin       <= rd_bin_next;
            rd_gray      <= to_gray(rd_bin_next);
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            if (load_out) begin
                out_valid <= !empty;
            end
        end
    end

    // The registered in_ready must never let a write through while the stored
    // pointer already sits one lap ahead of the synchronized read pointer.
    a_wr_not_full: assert property (
        @(posedge clk) disable iff (!wr_rst_n)
        wr_en |-> (wr_gray != {~rd_gray_sync[PTR_W-1:PTR_W-2], rd_gray_sync[PTR_W-3:0]})
    ) else $error("cdc_fifo write pointer moved while full");

    a_rd_not_empty: assert property (
        @(posedge clk_out) disable iff (!rd_rst_n)
        !$stable(rd_bin) |-> !$past(empty)
    ) else $error("cdc_fifo read pointer moved while empty");

endmodule

// File: priority_arbiter.sv
`timescale 1ns/1ps

module priority_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  stream_pkg::data_word_t  src0_data,
    input  stream_pkg::data_word_t  src1_data,
    input  logic                    src0_valid,
    input  logic                    src1_valid,
    output logic                    src0_ready,
    output logic                    src1_ready,
    output stream_pkg::merge_beat_t beat,
    output logic                    beat_valid,
    input  logic                    beat_ready
);
    import stream_pkg::*;

    logic        load;
    logic        any_valid;
    merge_beat_t chosen;

    // The output register can load when it is empty or its beat leaves now.
    assign load      = !beat_valid || beat_ready;
    assign any_valid = src0_valid || src1_valid;

    // Source 1 always wins. Source 0 only gets through while source 1 is idle.
    assign src1_ready = load;
    assign src0_ready = load && !src1_valid;

    always_comb begin
        if (src1_valid) begin
            chosen.data   = src1_data;
            chosen.source = source_t'(1);
        end else begin
            chosen.data   = src0_data;
            chosen.source = source_t'(0);
        end
    end

    always_ff @(posedge clk) begin
        if (load && any_valid) begin
            beat <= chosen;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_valid <= 1'b0;
        end else if (load) begin
            beat_valid <= any_valid;
        end
    end

    a_src1_first: assert property (
        @(posedge clk) disable iff (!arst_n)
        (load && src1_valid) |=>
            (beat.source == source_t'(1) && beat.data == $past(src1_data))
    ) else $error("priority_arbiter passed source 0 ahead of a valid source 1");

    a_beat_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (beat_valid && !beat_ready) |=> (beat_valid && $stable(beat))
    ) else $error("priority_arbiter changed a stalled beat");

endmodule

// File: input_fifo.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module input_fifo (
    input  logic                   clk,
    input  logic                   arst_n,
    input  stream_pkg::data_word_t in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    output logic                   almost_full,
    output stream_pkg::data_word_t out_data,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import stream_pkg::*;
    import fifo_pkg::*;

    localparam in_level_t DEPTH_LEVEL = in_level_t'(`MERGE_IN_DEPTH);
    localparam in_level_t FULL_LEVEL  = in_level_t'(`MERGE_FULL_LEVEL);
    localparam in_addr_t  LAST_ADDR   = in_addr_t'(`MERGE_IN_DEPTH - 1);

    data_word_t mem [`MERGE_IN_DEPTH];
    in_addr_t   wr_ptr;
    in_addr_t   rd_ptr;
    in_level_t  level;
    in_level_t  level_next;
    logic       wr_en;
    logic       rd_en;
    logic       load_out;

    assign wr_en = in_valid && in_ready;

    // The output register takes a new word when it is empty or being drained.
    assign load_out = !out_valid || out_ready;
    assign rd_en    = load_out && (level != '0);

    always_comb begin
        level_next = level;
        if (wr_en && !rd_en) begin
            level_next = level + in_level_t'(1);
        end else if (rd_en && !wr_en) begin
            level_next = level - in_level_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            level       <= '0;
            in_ready    <= 1'b0;
            almost_full <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + in_addr_t'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + in_addr_t'(1);
            end
            level <= level_next;
            // Ready is taken from the next level so it drops on the same edge the
            // FIFO becomes full.
            in_ready <= (level_next != DEPTH_LEVEL);
            // Almost full follows the stored level one cycle later.
            almost_full <= (level >= FULL_LEVEL);
            if (load_out) begin
                out_valid <= (level != '0);
            end
        end
    end

    a_level_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        level <= DEPTH_LEVEL
    ) else $error("input_fifo level above depth");

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (level == DEPTH_LEVEL) |-> !wr_en
    ) else $error("input_fifo accepted a word while full");

endmodule

// File: fifo_pkg.sv
`include "merge_consts.svh"

package fifo_pkg;

    // Storage address inside an input FIFO.
    typedef logic [$clog2(`MERGE_IN_DEPTH)-1:0] in_addr_t;

    // Fill count of an input FIFO. It covers 0 up to the full depth.
    typedef logic [$clog2(`MERGE_IN_DEPTH+1)-1:0] in_level_t;

    // Crossing FIFO pointer with one extra wrap bit in binary or Gray form.
    typedef logic [$clog2(`MERGE_CDC_DEPTH):0] cdc_ptr_t;

endpackage

// File: stream_pkg.sv
`include "merge_consts.svh"

package stream_pkg;

    // One payload word as it enters from a producer.
    typedef logic [`MERGE_DATA_W-1:0] data_word_t;

    // Number of the producer that sent a word.
    typedef logic [0:0] source_t;

    // A beat after arbitration carries its data and the source it came from.
    typedef struct packed {
        data_word_t data;
        source_t    source;
    } merge_beat_t;

endpackage

// File: merge_consts.svh
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// Width of one payload word.
`define MERGE_DATA_W 8

// Words held by each input FIFO.
`define MERGE_IN_DEPTH 16

// Input fill level at which almost_full is raised.
`define MERGE_FULL_LEVEL 12

// Words in the crossing FIFO. This must be a power of two.
`define MERGE_CDC_DEPTH 8

`endif
